/* common/noc_config.svh */
// Router dimensions shared by the package, the RTL and the testbench; include wherever a size is needed
`ifndef NOC_CONFIG_SVH
`define NOC_CONFIG_SVH

// Inputs and outputs of the router
`define NOC_NUM_PORTS 4

// Payload bits carried by each flit
`define NOC_FLIT_WIDTH 32

// Width of the destination field in a flit
`define NOC_DEST_WIDTH 3

// Routing table entries, one per destination endpoint
`define NOC_NUM_ENDPOINTS 8

// Flits per input buffer
// The downstream credit counters start at this value
`define NOC_BUFFER_DEPTH 4

`endif

/* common/noc_pkg.sv */
// Router types for links, routing table and control state; referenced by scoped names
`default_nettype none

`include "noc_config.svh"

package noc_pkg;

    // Flit payload
    typedef logic [`NOC_FLIT_WIDTH-1:0] flit_data_t;

    // Destination endpoint, valid on head flits
    typedef logic [`NOC_DEST_WIDTH-1:0] dest_t;

    // Port number
    typedef logic [$clog2(`NOC_NUM_PORTS)-1:0] port_idx_t;

    // One bit per port, for requests and grants
    typedef logic [`NOC_NUM_PORTS-1:0] port_mask_t;

    // Credits from 0 up to the full buffer depth
    typedef logic [$clog2(`NOC_BUFFER_DEPTH+1)-1:0] credit_cnt_t;

    // Payload of every link
    typedef struct packed {
        flit_data_t data;
        dest_t      dest;
        logic       is_tail;
    } flit_t;

    // Entry d holds the output port for destination d
    typedef port_idx_t [`NOC_NUM_ENDPOINTS-1:0] route_table_t;

    // Whether the next arriving flit starts a packet
    typedef enum logic {RX_IDLE, RX_BODY} rx_state_e;

    // Whether an output is reserved for a packet in flight
    typedef enum logic {LOCK_FREE, LOCK_HELD} lock_state_e;

endpackage

`default_nettype wire

/* input_unit/flit_fifo.sv */
// Synchronous first-word fall-through FIFO; used by the input unit for flits and destinations
`timescale 1ns/1ps
`default_nettype none

module flit_fifo #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 4
) (
    input  wire              clk,
    input  wire              rst_n,
    input  wire              wr_en,
    input  wire  [WIDTH-1:0] wr_data,
    input  wire              rd_en,
    output logic [WIDTH-1:0] rd_data,
    output logic             empty
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    // Wrap explicitly so any depth works, not only powers of two
    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + PTR_W'(1);
    endfunction

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    // Upstream credits keep writes from reaching a full buffer
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (rd_en) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + CNT_W'(1);
                2'b01:   count <= count - CNT_W'(1);
                default: count <= count;
            endcase
        end
    end

    // Front entry is visible without a read request
    assign rd_data = mem[rd_ptr];
    assign empty   = (count == '0);

endmodule

`default_nettype wire

/* input_unit/input_unit.sv */
// Router input port with flit and destination buffers and the route lookup, one per port
`timescale 1ns/1ps
`default_nettype none

`include "noc_config.svh"

module input_unit (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire                   send_in,
    input  wire  noc_pkg::flit_t  flit_in,
    input  wire  noc_pkg::route_table_t route_table,
    input  wire                   pop,
    output noc_pkg::flit_t        head_flit,
    output logic                  head_valid,
    output noc_pkg::port_idx_t    req_port,
    output logic                  credit_out
);

    localparam int FLIT_FIFO_W = $bits(noc_pkg::flit_data_t) + 1;
    localparam int DEST_FIFO_W = $bits(noc_pkg::dest_t);

    noc_pkg::rx_state_e     rx_state;
    logic [FLIT_FIFO_W-1:0] flit_rd_data;
    logic                   flit_empty;
    noc_pkg::dest_t         dest_rd_data;
    logic                   dest_wr_en;
    logic                   dest_rd_en;

    // Track packet boundaries on the arriving side
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rx_state <= noc_pkg::RX_IDLE;
        end else if (send_in) begin
            rx_state <= flit_in.is_tail ? noc_pkg::RX_IDLE : noc_pkg::RX_BODY;
        end
    end

    // Only head flits carry a destination worth storing
    assign dest_wr_en = send_in && (rx_state == noc_pkg::RX_IDLE);

    // The packet's destination is retired together with its tail
    assign dest_rd_en = pop && head_flit.is_tail;

    flit_fifo #(
        .WIDTH (FLIT_FIFO_W),
        .DEPTH (`NOC_BUFFER_DEPTH)
    ) u_flit_buf (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_en   (send_in),
        .wr_data ({flit_in.data, flit_in.is_tail}),
        .rd_en   (pop),
        .rd_data (flit_rd_data),
        .empty   (flit_empty)
    );

    // A packet's entry stays until its tail leaves, so it is never behind its flits
    flit_fifo #(
        .WIDTH (DEST_FIFO_W),
        .DEPTH (`NOC_BUFFER_DEPTH)
    ) u_dest_buf (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_en   (dest_wr_en),
        .wr_data (flit_in.dest),
        .rd_en   (dest_rd_en),
        .rd_data (dest_rd_data),
        .empty   ()
    );

    // Every flit of a packet leaves with the head's destination
    assign head_flit.data    = flit_rd_data[FLIT_FIFO_W-1:1];
    assign head_flit.is_tail = flit_rd_data[0];
    assign head_flit.dest    = dest_rd_data;

    assign head_valid = !flit_empty;

    assign req_port   = route_table[head_flit.dest];

    // A freed buffer slot goes straight back upstream
    assign credit_out = pop;

endmodule

`default_nettype wire

/* hdl/switch_allocator.sv */
// Per-output least-recently-granted arbitration with packet lock; grants also pop the inputs
`timescale 1ns/1ps
`default_nettype none

`include "noc_config.svh"

module switch_allocator (
    input  wire                                      clk,
    input  wire                                      rst_n,
    input  wire  noc_pkg::port_mask_t                head_valid,
    input  wire  noc_pkg::port_mask_t                head_is_tail,
    input  wire  noc_pkg::port_idx_t [`NOC_NUM_PORTS-1:0] req_port,
    input  wire  noc_pkg::port_mask_t                has_credit,
    output noc_pkg::port_mask_t [`NOC_NUM_PORTS-1:0] grant,
    output noc_pkg::port_mask_t                      pop
);

    localparam int N = `NOC_NUM_PORTS;

    // prio[o][i][j] set means input i wins over input j at output o
    logic [N-1:0][N-1:0][N-1:0]      prio;
    noc_pkg::lock_state_e            lock_state [N];
    noc_pkg::port_idx_t  [N-1:0]     lock_owner;
    noc_pkg::port_mask_t [N-1:0]     req;
    noc_pkg::port_mask_t [N-1:0]     elig;
    noc_pkg::port_mask_t [N-1:0]     win;
    noc_pkg::port_idx_t  [N-1:0]     grant_idx;

    always_comb begin
        for (int o = 0; o < N; o++) begin
            for (int i = 0; i < N; i++) begin
                req[o][i] = head_valid[i] && (req_port[i] == noc_pkg::port_idx_t'(o));
            end

            // A locked output only listens to the packet it is carrying
            if (lock_state[o] == noc_pkg::LOCK_HELD) begin
                elig[o] = req[o] & (noc_pkg::port_mask_t'(1) << lock_owner[o]);
            end else begin
                elig[o] = req[o];
            end

            for (int i = 0; i < N; i++) begin
                win[o][i] = elig[o][i];
                for (int j = 0; j < N; j++) begin
                    if (j != i && elig[o][j] && !prio[o][i][j]) begin
                        win[o][i] = 1'b0;
                    end
                end
            end

            // No credit, no grant; the lock holds meanwhile
            grant[o] = has_credit[o] ? win[o] : '0;

            grant_idx[o] = '0;
            for (int i = 0; i < N; i++) begin
                if (grant[o][i]) begin
                    grant_idx[o] = noc_pkg::port_idx_t'(i);
                end
            end
        end

        // An input requests one output at a time
        for (int i = 0; i < N; i++) begin
            pop[i] = 1'b0;
            for (int o = 0; o < N; o++) begin
                pop[i] = pop[i] | grant[o][i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int o = 0; o < N; o++) begin
                lock_state[o] <= noc_pkg::LOCK_FREE;
                lock_owner[o] <= '0;
                for (int i = 0; i < N; i++) begin
                    for (int j = 0; j < N; j++) begin
                        prio[o][i][j] <= (i < j);
                    end
                end
            end
        end else begin
            for (int o = 0; o < N; o++) begin
                if (|grant[o]) begin
                    if (|(grant[o] & head_is_tail)) begin
                        lock_state[o] <= noc_pkg::LOCK_FREE;
                    end else begin
                        lock_state[o] <= noc_pkg::LOCK_HELD;
                        lock_owner[o] <= grant_idx[o];
                    end
                    // Winner drops below every other input
                    for (int i = 0; i < N; i++) begin
                        for (int j = 0; j < N; j++) begin
                            if (i != j && grant[o][i]) begin
                                prio[o][i][j] <= 1'b0;
                            end else if (i != j && grant[o][j]) begin
                                prio[o][i][j] <= 1'b1;
                            end
                        end
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/output_unit.sv */
// Router output port: crossbar column driven by the grant, plus the downstream credit counter
`timescale 1ns/1ps
`default_nettype none

`include "noc_config.svh"

module output_unit (
    input  wire                                  clk,
    input  wire                                  rst_n,
    input  wire  noc_pkg::port_mask_t            grant,
    input  wire  noc_pkg::flit_t [`NOC_NUM_PORTS-1:0] head_flit,
    input  wire                                  credit_in,
    output logic                                 has_credit,
    output logic                                 send_out,
    output noc_pkg::flit_t                       flit_out
);

    localparam int N = `NOC_NUM_PORTS;

    noc_pkg::credit_cnt_t credit_cnt;
    noc_pkg::credit_cnt_t credit_nxt;

    // Grant is one-hot or zero, so an OR of masked inputs is the mux
    always_comb begin
        flit_out = '0;
        for (int i = 0; i < N; i++) begin
            if (grant[i]) begin
                flit_out = flit_out | head_flit[i];
            end
        end
    end

    // The allocator already checked credits
    assign send_out = |grant;

    // Returned credits and sent flits may land in the same cycle
    assign credit_nxt = credit_cnt
                        + noc_pkg::credit_cnt_t'(credit_in)
                        - noc_pkg::credit_cnt_t'(send_out);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            credit_cnt <= noc_pkg::credit_cnt_t'(`NOC_BUFFER_DEPTH);
        end else begin
            credit_cnt <= credit_nxt;
        end
    end

    assign has_credit = (credit_cnt != '0);

endmodule

`default_nettype wire

/* hdl/noc_router.sv */
// Four-port wormhole router top level; connects input units, switch allocator and output units
`timescale 1ns/1ps
`default_nettype none

`include "noc_config.svh"

module noc_router (
    input  wire                                  clk,
    input  wire                                  rst_n,
    input  wire  noc_pkg::port_mask_t            send_in,
    input  wire  noc_pkg::flit_t [`NOC_NUM_PORTS-1:0] flit_in,
    output wire  noc_pkg::port_mask_t            credit_out,
    output wire  noc_pkg::port_mask_t            send_out,
    output wire  noc_pkg::flit_t [`NOC_NUM_PORTS-1:0] flit_out,
    input  wire  noc_pkg::port_mask_t            credit_in,
    input  wire  noc_pkg::route_table_t          route_table
);

    localparam int N = `NOC_NUM_PORTS;

    wire noc_pkg::flit_t      [N-1:0] head_flit;
    wire noc_pkg::port_mask_t         head_valid;
    wire noc_pkg::port_mask_t         head_is_tail;
    wire noc_pkg::port_idx_t  [N-1:0] req_port;
    wire noc_pkg::port_mask_t         pop;
    wire noc_pkg::port_mask_t [N-1:0] grant;
    wire noc_pkg::port_mask_t         has_credit;

    for (genvar i = 0; i < N; i++) begin : g_in
        input_unit u_input (
            .clk         (clk),
            .rst_n       (rst_n),
            .send_in     (send_in[i]),
            .flit_in     (flit_in[i]),
            .route_table (route_table),
            .pop         (pop[i]),
            .head_flit   (head_flit[i]),
            .head_valid  (head_valid[i]),
            .req_port    (req_port[i]),
            .credit_out  (credit_out[i])
        );

        assign head_is_tail[i] = head_flit[i].is_tail;
    end

    switch_allocator u_alloc (
        .clk          (clk),
        .rst_n        (rst_n),
        .head_valid   (head_valid),
        .head_is_tail (head_is_tail),
        .req_port     (req_port),
        .has_credit   (has_credit),
        .grant        (grant),
        .pop          (pop)
    );

    // Each output sees every input head and picks by its grant
    for (genvar o = 0; o < N; o++) begin : g_out
        output_unit u_output (
            .clk        (clk),
            .rst_n      (rst_n),
            .grant      (grant[o]),
            .head_flit  (head_flit),
            .credit_in  (credit_in[o]),
            .has_credit (has_credit[o]),
            .send_out   (send_out[o]),
            .flit_out   (flit_out[o])
        );
    end

endmodule

`default_nettype wire

/* dv/tb_clock_gen.sv */
// Testbench clock and reset source, instantiated once in the testbench top
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 16
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // Reset is synchronous, so hold it across a number of rising edges
    initial begin
        rst_n <= 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

`default_nettype wire

/* dv/router_props.sv */
// Concurrent assertions on the router top level, attached to every noc_router by the bind below
`timescale 1ns/1ps
`default_nettype none

`include "noc_config.svh"

module router_props (
    input wire                                      clk,
    input wire                                      rst_n,
    input wire noc_pkg::port_mask_t [`NOC_NUM_PORTS-1:0] grant,
    input wire noc_pkg::port_mask_t                 send_in,
    input wire noc_pkg::port_mask_t                 credit_out,
    input wire noc_pkg::port_mask_t                 send_out,
    input wire noc_pkg::port_mask_t                 credit_in
);

    // Downstream credits and input buffer fill, rebuilt from the link pulses alone
    noc_pkg::credit_cnt_t [`NOC_NUM_PORTS-1:0] out_credits;
    noc_pkg::credit_cnt_t [`NOC_NUM_PORTS-1:0] in_fill;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int p = 0; p < `NOC_NUM_PORTS; p++) begin
                out_credits[p] <= noc_pkg::credit_cnt_t'(`NOC_BUFFER_DEPTH);
                in_fill[p]     <= '0;
            end
        end else begin
            for (int p = 0; p < `NOC_NUM_PORTS; p++) begin
                out_credits[p] <= out_credits[p]
                                  + noc_pkg::credit_cnt_t'(credit_in[p])
                                  - noc_pkg::credit_cnt_t'(send_out[p]);
                in_fill[p]     <= in_fill[p]
                                  + noc_pkg::credit_cnt_t'(send_in[p])
                                  - noc_pkg::credit_cnt_t'(credit_out[p]);
            end
        end
    end

    for (genvar p = 0; p < `NOC_NUM_PORTS; p++) begin : g_port
        // One input at most drives an output in a cycle
        a_grant_onehot: assert property (@(posedge clk) disable iff (!rst_n)
            $onehot0(grant[p]))
            else $error("grant for output %0d has more than one bit set", p);

        a_send_needs_credit: assert property (@(posedge clk) disable iff (!rst_n)
            send_out[p] |-> (out_credits[p] != '0))
            else $error("output %0d sent a flit with no downstream credit", p);

        // A credit is only returned for a flit leaving a non-empty buffer
        a_credit_needs_flit: assert property (@(posedge clk) disable iff (!rst_n)
            credit_out[p] |-> (in_fill[p] != '0))
            else $error("input %0d returned a credit while its buffer was empty", p);
    end

endmodule

bind noc_router router_props u_props (
    .clk        (clk),
    .rst_n      (rst_n),
    .grant      (grant),
    .send_in    (send_in),
    .credit_out (credit_out),
    .send_out   (send_out),
    .credit_in  (credit_in)
);

`default_nettype wire

/* dv/router_tb.sv */
// Random wormhole traffic testbench for the router, run as the simulation top with sim.f
`timescale 1ns/1ps
`default_nettype none

`include "noc_config.svh"

module router_tb #(
    parameter int unsigned SEED = 32'h9eb6_4ccd
);

    localparam int N           = `NOC_NUM_PORTS;
    localparam int DEPTH       = `NOC_BUFFER_DEPTH;
    localparam int NUM_PACKETS = 24;
    localparam int MAX_LEN     = 4;
    localparam int TIMEOUT     = NUM_PACKETS * MAX_LEN * N * 40 + 2000;
    localparam int STALL_START = 100;
    localparam int STALL_END   = 300;
    // The source input travels in the top bits of the payload
    localparam int SRC_W       = $bits(noc_pkg::port_idx_t);
    localparam int SRC_MSB     = `NOC_FLIT_WIDTH - 1;

    logic                              clk;
    logic                              rst_n;
    noc_pkg::port_mask_t               send_in;
    noc_pkg::flit_t      [N-1:0]       flit_in;
    noc_pkg::port_mask_t               credit_out;
    noc_pkg::port_mask_t               send_out;
    noc_pkg::flit_t      [N-1:0]       flit_out;
    noc_pkg::port_mask_t               credit_in;
    noc_pkg::route_table_t             route_table;

    // Expected flits, indexed by source * N + output
    noc_pkg::flit_t exp_q [N*N][$];
    int pkts_left [N];
    int flits_left [N];
    noc_pkg::dest_t cur_dest [N];
    int src_sent [N];
    int credit_pulses [N];
    int out_sends [N];
    int returned [N];
    int cred_seen [N];
    logic owner_valid [N];
    noc_pkg::port_idx_t owner [N];
    int value_errors;
    int other_errors;
    int checked;
    int cycle;

    tb_clock_gen u_clk (
        .clk   (clk),
        .rst_n (rst_n)
    );

    noc_router dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .send_in     (send_in),
        .flit_in     (flit_in),
        .credit_out  (credit_out),
        .send_out    (send_out),
        .flit_out    (flit_out),
        .credit_in   (credit_in),
        .route_table (route_table)
    );

    // Reference routing sends destination d to the port in entry d
    function automatic noc_pkg::port_idx_t expected_port(input noc_pkg::route_table_t tbl,
                                                         input noc_pkg::dest_t d);
        return tbl[d];
    endfunction

    task automatic check_flit(input string name, input noc_pkg::flit_t got,
                              input noc_pkg::flit_t want);
        checked++;
        if (got !== want) begin
            value_errors++;
            $display("CHECK FAILED %s got %h expected %h", name, got, want);
        end
    endtask

    task automatic check_count(input string name, input noc_pkg::credit_cnt_t got,
                               input noc_pkg::credit_cnt_t want);
        checked++;
        if (got !== want) begin
            value_errors++;
            $display("CHECK FAILED %s got %h expected %h", name, got, want);
        end
    endtask

    function automatic bit traffic_pending();
        for (int i = 0; i < N; i++) begin
            if (pkts_left[i] > 0 || flits_left[i] > 0 || src_sent[i] != credit_pulses[i]) begin
                return 1'b1;
            end
            if (out_sends[i] != returned[i]) begin
                return 1'b1;
            end
        end
        for (int q = 0; q < N * N; q++) begin
            if (exp_q[q].size() != 0) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    // Runs on each rising edge and lets a source send only while it holds a credit
    task automatic drive_cycle(input bit stall);
        noc_pkg::flit_t f;
        int credits;
        bit head;
        for (int i = 0; i < N; i++) begin
            credits = DEPTH - src_sent[i] + credit_pulses[i];
            if ((flits_left[i] > 0 || pkts_left[i] > 0) && credits > 0 && ($urandom % 4) != 0) begin
                head = (flits_left[i] == 0);
                if (head) begin
                    flits_left[i] = int'($urandom % MAX_LEN) + 1;
                    cur_dest[i] = noc_pkg::dest_t'($urandom);
                    pkts_left[i]--;
                end
                f.data = noc_pkg::flit_data_t'($urandom);
                f.data[SRC_MSB -: SRC_W] = SRC_W'(i);
                f.is_tail = (flits_left[i] == 1);
                // Body flits carry junk in dest that the router must ignore
                f.dest = head ? cur_dest[i] : noc_pkg::dest_t'($urandom);
                send_in[i] <= 1'b1;
                flit_in[i] <= f;
                f.dest = cur_dest[i];
                exp_q[i * N + int'(expected_port(route_table, cur_dest[i]))].push_back(f);
                flits_left[i]--;
                src_sent[i]++;
            end else begin
                send_in[i] <= 1'b0;
            end
        end
        // Downstream sinks drain slowly, and not at all during the stall window
        for (int o = 0; o < N; o++) begin
            if (!stall && out_sends[o] > returned[o] && ($urandom % 2) != 0) begin
                credit_in[o] <= 1'b1;
                returned[o]++;
            end else begin
                credit_in[o] <= 1'b0;
            end
        end
    endtask

    // Monitor samples mid-cycle, where the combinational outputs are settled
    initial begin
        int src;
        noc_pkg::flit_t want;
        forever begin
            @(negedge clk);
            if (rst_n) begin
                for (int o = 0; o < N; o++) begin
                    if (send_out[o]) begin
                        src = int'(flit_out[o].data[SRC_MSB -: SRC_W]);
                        if (owner_valid[o] && noc_pkg::port_idx_t'(src) != owner[o]) begin
                            other_errors++;
                            $display("Output %0d carried input %0d inside a packet from input %0d",
                                     o, src, owner[o]);
                        end
                        if (out_sends[o] + 1 > DEPTH + cred_seen[o]) begin
                            other_errors++;
                            $display("Output %0d sent more flits than it had credits", o);
                        end
                        if (exp_q[src * N + o].size() == 0) begin
                            other_errors++;
                            $display("Output %0d sent a flit that no source sent there", o);
                        end else begin
                            want = exp_q[src * N + o].pop_front();
                            check_flit($sformatf("flit_out[%0d]", o), flit_out[o], want);
                        end
                        owner_valid[o] = !flit_out[o].is_tail;
                        owner[o] = noc_pkg::port_idx_t'(src);
                        out_sends[o]++;
                    end
                    cred_seen[o] += int'(credit_in[o]);
                end
                for (int i = 0; i < N; i++) begin
                    if (credit_out[i]) begin
                        if (credit_pulses[i] >= src_sent[i]) begin
                            other_errors++;
                            $display("Input %0d returned a credit with no flit outstanding", i);
                        end
                        credit_pulses[i]++;
                    end
                end
            end
        end
    end

    initial begin
        repeat (TIMEOUT) @(posedge clk);
        $display("Watchdog expired after %0d cycles with traffic still pending", TIMEOUT);
        $display("Summary: %0d checks, %0d value errors, %0d other errors",
                 checked, value_errors, other_errors);
        $display("Checks failed");
        $finish;
    end

    initial begin
        void'($urandom(SEED));
        send_in   <= '0;
        flit_in   <= '0;
        credit_in <= '0;
        for (int d = 0; d < `NOC_NUM_ENDPOINTS; d++) begin
            route_table[d] = noc_pkg::port_idx_t'($urandom);
        end
        for (int i = 0; i < N; i++) begin
            pkts_left[i] = NUM_PACKETS;
            flits_left[i] = 0;
            cur_dest[i] = '0;
            src_sent[i] = 0;
            credit_pulses[i] = 0;
            out_sends[i] = 0;
            returned[i] = 0;
            cred_seen[i] = 0;
            owner_valid[i] = 1'b0;
            owner[i] = '0;
        end
        value_errors = 0;
        other_errors = 0;
        checked = 0;
        cycle = 0;

        wait (rst_n);
        // The monitor flags any output during this idle window
        repeat (8) @(posedge clk);
        while (traffic_pending()) begin
            @(posedge clk);
            drive_cycle(cycle >= STALL_START && cycle < STALL_END);
            cycle++;
        end
        @(posedge clk);
        send_in   <= '0;
        credit_in <= '0;
        repeat (3) @(posedge clk);

        for (int p = 0; p < N; p++) begin
            check_count($sformatf("credit_out[%0d] balance", p),
                        noc_pkg::credit_cnt_t'(DEPTH - src_sent[p] + credit_pulses[p]),
                        noc_pkg::credit_cnt_t'(DEPTH));
            check_count($sformatf("send_out[%0d] balance", p),
                        noc_pkg::credit_cnt_t'(DEPTH - out_sends[p] + cred_seen[p]),
                        noc_pkg::credit_cnt_t'(DEPTH));
        end

        $display("Summary: %0d checks, %0d value errors, %0d other errors",
                 checked, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sim.f */
+incdir+common
common/noc_pkg.sv
input_unit/flit_fifo.sv
input_unit/input_unit.sv
hdl/switch_allocator.sv
hdl/output_unit.sv
hdl/noc_router.sv
dv/tb_clock_gen.sv
dv/router_props.sv
dv/router_tb.sv

/* Makefile */
# Verilator simulation of the router testbench

TOP       ?= router_tb
SEED      ?= 9eb64ccd
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -GSEED=32\'h$(SEED) -Mdir $(OBJ_DIR) -f sim.f
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Checks failed" $(LOG); then echo "Simulation failed, see $(LOG)"; exit 1; fi
	@grep -q "All checks passed" $(LOG) || { echo "Simulation did not finish, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
